// File: rtl/i8008_pkg.sv
/* Shared widths, register and opcode field codes, ALU and condition encodings,
   flags, the instruction union and the control states of the 8008-style core. */
package i8008_pkg;

  localparam int DATA_W              = 8;
  localparam int ADDR_W              = 16;
  localparam int PORT_W              = 5;
  localparam int STACK_DEPTH_DEFAULT = 8;

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [ADDR_W-1:0] addr_t;

  // Register codes. M is memory at H:L.
  localparam logic [2:0] REG_A = 3'd0;
  localparam logic [2:0] REG_H = 3'd5;
  localparam logic [2:0] REG_L = 3'd6;
  localparam logic [2:0] REG_M = 3'd7;

  // Opcode groups in bits 7:6.
  localparam logic [1:0] GRP_IMM = 2'b00;
  localparam logic [1:0] GRP_JMP = 2'b01;
  localparam logic [1:0] GRP_ALU = 2'b10;
  localparam logic [1:0] GRP_MOV = 2'b11;

  // Low field of group 00 forms that take an immediate byte.
  localparam logic [2:0] LO_ALU_IMM = 3'b100;
  localparam logic [2:0] LO_MVI     = 3'b110;

  typedef enum logic [2:0] {
    op_add, op_adc, op_sub, op_sbb, op_ana, op_xra, op_ora, op_cmp
  } alu_op_e;

  typedef enum logic [2:0] {
    cond_nc, cond_nz, cond_p, cond_po, cond_c, cond_z, cond_m, cond_pe
  } cond_e;

  typedef struct packed {
    logic parity;
    logic sign;
    logic carry;
    logic zero;
  } flags_t;

  typedef struct packed {
    logic [1:0] group;
    logic [2:0] dst;
    logic [2:0] src;
  } reg_form_t;

  // OUT view. Bit 0 set in group 01 marks an I/O opcode.
  typedef struct packed {
    logic [1:0]        group;
    logic [PORT_W-1:0] port;
    logic              is_io;
  } io_form_t;

  typedef union packed {
    reg_form_t reg_form;
    io_form_t  io_form;
  } instr_u;

  typedef enum logic [4:0] {
    st_idle, st_fetch_0, st_fetch_1, st_lo_0, st_lo_1, st_hi_0, st_hi_1,
    st_exec, st_mem_rd, st_out, st_halted
  } state_e;

endpackage

// File: rtl/alu.sv
/* Eight-operation 8-bit ALU with a 9-bit result and the zero, carry, sign and
   parity flags. */
`timescale 1ns/1ps

module alu (
  input  i8008_pkg::data_t   a,
  input  i8008_pkg::data_t   b,
  input  i8008_pkg::alu_op_e op,
  input  logic               carry_in,
  output logic [8:0]         result,
  output i8008_pkg::flags_t  flags
);

  always_comb begin
    case (op)
      i8008_pkg::op_add: result = {1'b0, a} + {1'b0, b};
      i8008_pkg::op_adc: result = {1'b0, a} + {1'b0, b} + 9'(carry_in);
      // Bit 8 of a difference is the borrow.
      i8008_pkg::op_sub: result = {1'b0, a} - {1'b0, b};
      i8008_pkg::op_sbb: result = {1'b0, a} - {1'b0, b} - 9'(carry_in);
      i8008_pkg::op_ana: result = {1'b0, a & b};
      i8008_pkg::op_xra: result = {1'b0, a ^ b};
      i8008_pkg::op_ora: result = {1'b0, a | b};
      i8008_pkg::op_cmp: result = {1'b0, a} - {1'b0, b};
      default:           result = '0;
    endcase

    flags.zero   = result[7:0] == 8'd0;
    flags.carry  = result[8];
    flags.sign   = result[7];
    // Set on an even count of ones.
    flags.parity = ~^result[7:0];
  end

endmodule

// File: rtl/reg_file.sv
/* Seven 8-bit registers with two read ports, one write port and the H:L pointer. */
`timescale 1ns/1ps

module reg_file (
  input  logic             raw_clk,
  input  logic [2:0]       rd_sel_a,
  input  logic [2:0]       rd_sel_b,
  output i8008_pkg::data_t rd_a,
  output i8008_pkg::data_t rd_b,
  input  logic             wr_en,
  input  logic [2:0]       wr_sel,
  input  i8008_pkg::data_t wr_data,
  output i8008_pkg::addr_t hl
);

  i8008_pkg::data_t regs [0:6];

  // Code 7 is M and has no register behind it.
  assign rd_a = (rd_sel_a == i8008_pkg::REG_M) ? '0 : regs[rd_sel_a];
  assign rd_b = (rd_sel_b == i8008_pkg::REG_M) ? '0 : regs[rd_sel_b];
  assign hl   = {regs[i8008_pkg::REG_H], regs[i8008_pkg::REG_L]};

  always_ff @(posedge raw_clk) begin
    if (wr_en && wr_sel != i8008_pkg::REG_M)
      regs[wr_sel] <= wr_data;
  end

endmodule

// File: rtl/call_stack.sv
/* Return-address stack with push and pop and a pointer that wraps at the depth. */
`timescale 1ns/1ps

module call_stack #(
  parameter int stack_depth = i8008_pkg::STACK_DEPTH_DEFAULT
) (
  input  logic             raw_clk,
  input  logic             button_reset,
  input  logic             push,
  input  logic             pop,
  input  i8008_pkg::addr_t push_addr,
  output i8008_pkg::addr_t top_addr
);

  localparam int ptr_w = (stack_depth > 1) ? $clog2(stack_depth) : 1;
  localparam logic [ptr_w-1:0] last_idx = ptr_w'(stack_depth - 1);

  i8008_pkg::addr_t entries [stack_depth];
  logic [ptr_w-1:0] sp;
  logic [ptr_w-1:0] top_idx;

  // Slot below the pointer holds the latest push.
  assign top_idx  = (sp == '0) ? last_idx : sp - 1'b1;
  assign top_addr = entries[top_idx];

  always_ff @(posedge raw_clk) begin
    if (!button_reset)
      sp <= '0;
    else if (push)
      sp <= (sp == last_idx) ? '0 : sp + 1'b1;
    else if (pop)
      sp <= top_idx;
  end

  always_ff @(posedge raw_clk) begin
    if (push)
      entries[sp] <= push_addr;
  end

endmodule

// File: rtl/program_ram.sv
/* Single-port program RAM with a load path for the idle core and a core path. */
`timescale 1ns/1ps

module program_ram #(
  parameter int mem_addr_w = 8
) (
  input  logic                  raw_clk,
  input  logic                  load_valid,
  input  logic [mem_addr_w-1:0] load_addr,
  input  i8008_pkg::data_t      load_data,
  input  i8008_pkg::addr_t      mem_addr,
  input  logic                  mem_we,
  input  i8008_pkg::data_t      mem_wdata,
  output i8008_pkg::data_t      mem_rdata
);

  i8008_pkg::data_t mem [2**mem_addr_w];
  logic [mem_addr_w-1:0] core_addr;

  // Core addresses fold onto the RAM size.
  assign core_addr = mem_addr[mem_addr_w-1:0];

  always_ff @(posedge raw_clk) begin
    if (load_valid)
      mem[load_addr] <= load_data;
    else if (mem_we)
      mem[core_addr] <= mem_wdata;
    mem_rdata <= mem[core_addr];
  end

endmodule

// File: rtl/out_port.sv
/* OUT register with a credit counter, one-cycle valid and back-pressure on the core. */
`timescale 1ns/1ps

module out_port #(
  parameter int out_credits = 2
) (
  input  logic                         raw_clk,
  input  logic                         button_reset,
  input  logic                         out_req,
  input  logic [i8008_pkg::PORT_W-1:0] port,
  input  i8008_pkg::data_t             data,
  output logic                         out_grant,
  input  logic                         out_credit,
  output logic                         out_valid,
  output logic [i8008_pkg::PORT_W-1:0] out_port,
  output i8008_pkg::data_t             out_data
);

  localparam int cnt_w = $clog2(out_credits + 1);
  localparam logic [cnt_w-1:0] max_credits = cnt_w'(out_credits);

  logic [cnt_w-1:0] credits;

  // No grant without a credit in hand.
  assign out_grant = out_req && credits != '0;

  always_ff @(posedge raw_clk) begin
    if (!button_reset) begin
      credits   <= max_credits;
      out_valid <= 1'b0;
    end else begin
      out_valid <= out_grant;
      if (out_grant && !out_credit)
        credits <= credits - 1'b1;
      else if (!out_grant && out_credit && credits != max_credits)
        credits <= credits + 1'b1;
    end
  end

  always_ff @(posedge raw_clk) begin
    if (out_grant) begin
      out_port <= port;
      out_data <= data;
    end
  end

endmodule

// File: rtl/cpu_control.sv
/* Fetch/decode/execute FSM of the 8008-style core, holding the PC, the
   instruction and operand registers and the flags. */
`timescale 1ns/1ps

module cpu_control (
  input  logic                         raw_clk,
  input  logic                         button_reset,
  input  logic                         run,
  output logic                         halted,
  output i8008_pkg::addr_t             mem_addr,
  output logic                         mem_we,
  output i8008_pkg::data_t             mem_wdata,
  input  i8008_pkg::data_t             mem_rdata,
  output logic [2:0]                   rd_sel_a,
  output logic [2:0]                   rd_sel_b,
  input  i8008_pkg::data_t             rd_a,
  input  i8008_pkg::data_t             rd_b,
  output logic                         wr_en,
  output logic [2:0]                   wr_sel,
  output i8008_pkg::data_t             wr_data,
  input  i8008_pkg::addr_t             hl,
  output i8008_pkg::data_t             alu_a,
  output i8008_pkg::data_t             alu_b,
  output i8008_pkg::alu_op_e           alu_op,
  output logic                         alu_carry_in,
  input  logic [8:0]                   alu_result,
  input  i8008_pkg::flags_t            alu_flags,
  output logic                         push,
  output logic                         pop,
  output i8008_pkg::addr_t             push_addr,
  input  i8008_pkg::addr_t             top_addr,
  output logic                         out_req,
  output logic [i8008_pkg::PORT_W-1:0] port,
  output i8008_pkg::data_t             data,
  input  logic                         out_grant
);

  i8008_pkg::state_e state;
  i8008_pkg::instr_u ir;
  i8008_pkg::instr_u fetched;
  i8008_pkg::addr_t  pc;
  i8008_pkg::addr_t  opnd;
  i8008_pkg::flags_t flags;
  logic [1:0]        grp;
  logic [2:0]        dst;
  logic [2:0]        src;
  logic              is_halt;
  logic              is_mvi;
  logic              is_mov;
  logic              is_alu;
  logic              is_inc_dec;
  logic              is_jump;
  logic              is_call;
  logic              is_ret;
  logic              taken;
  logic              m_src;
  logic              reg_wr;
  logic              exec_now;

  function automatic logic cond_met(i8008_pkg::cond_e cc, i8008_pkg::flags_t f);
    logic hit;
    hit = 1'b0;
    case (cc)
      i8008_pkg::cond_nc: hit = !f.carry;
      i8008_pkg::cond_nz: hit = !f.zero;
      i8008_pkg::cond_p:  hit = !f.sign;
      i8008_pkg::cond_po: hit = !f.parity;
      i8008_pkg::cond_c:  hit = f.carry;
      i8008_pkg::cond_z:  hit = f.zero;
      i8008_pkg::cond_m:  hit = f.sign;
      i8008_pkg::cond_pe: hit = f.parity;
    endcase
    return hit;
  endfunction

  // Decode from the instruction register.
  assign fetched    = mem_rdata;
  assign grp        = ir.reg_form.group;
  assign dst        = ir.reg_form.dst;
  assign src        = ir.reg_form.src;
  assign is_halt    = ir == 8'h00 || ir == 8'h01 || ir == 8'hff;
  assign is_mvi     = grp == i8008_pkg::GRP_IMM && src == i8008_pkg::LO_MVI;
  assign is_mov     = grp == i8008_pkg::GRP_MOV && !is_halt;
  assign is_alu     = grp == i8008_pkg::GRP_ALU ||
                      (grp == i8008_pkg::GRP_IMM && src == i8008_pkg::LO_ALU_IMM);
  assign is_inc_dec = grp == i8008_pkg::GRP_IMM && src[2:1] == 2'b00 &&
                      dst != i8008_pkg::REG_A && dst != i8008_pkg::REG_M;
  assign is_jump    = grp == i8008_pkg::GRP_JMP && !ir.io_form.is_io && !src[1];
  assign is_call    = grp == i8008_pkg::GRP_JMP && !ir.io_form.is_io && src[1];
  assign is_ret     = grp == i8008_pkg::GRP_IMM && src[1:0] == 2'b11;
  // Bit 2 of the low field marks the unconditional form.
  assign taken      = src[2] || cond_met(i8008_pkg::cond_e'(dst), flags);
  assign m_src      = (grp == i8008_pkg::GRP_ALU || is_mov) && src == i8008_pkg::REG_M;
  assign reg_wr     = is_inc_dec || (is_alu && dst != i8008_pkg::op_cmp) ||
                      ((is_mvi || is_mov) && dst != i8008_pkg::REG_M);
  assign exec_now   = (state == i8008_pkg::st_exec && !m_src) ||
                      state == i8008_pkg::st_mem_rd;

  assign halted       = state == i8008_pkg::st_halted;
  assign mem_addr     = (state == i8008_pkg::st_exec) ? hl : pc;
  assign mem_we       = state == i8008_pkg::st_exec && (is_mvi || is_mov) &&
                        dst == i8008_pkg::REG_M;
  assign mem_wdata    = is_mvi ? opnd[7:0] : rd_a;
  assign rd_sel_a     = is_inc_dec ? dst : (is_mov ? src : i8008_pkg::REG_A);
  assign rd_sel_b     = src;
  assign wr_en        = reg_wr && exec_now;
  assign wr_sel       = is_alu ? i8008_pkg::REG_A : dst;
  assign alu_a        = rd_a;
  assign alu_op       = is_inc_dec ? (src[0] ? i8008_pkg::op_sub : i8008_pkg::op_add)
                                   : i8008_pkg::alu_op_e'(dst);
  assign alu_carry_in = flags.carry;
  assign push         = state == i8008_pkg::st_exec && is_call && taken;
  assign pop          = state == i8008_pkg::st_exec && is_ret && taken;
  assign push_addr    = pc;
  assign out_req      = state == i8008_pkg::st_out;
  assign port         = ir.io_form.port;
  assign data         = rd_a;

  always_comb begin
    if (state == i8008_pkg::st_mem_rd)
      alu_b = mem_rdata;
    else if (is_inc_dec)
      alu_b = 8'd1;
    else if (grp == i8008_pkg::GRP_ALU)
      alu_b = rd_b;
    else
      alu_b = opnd[7:0];

    if (state == i8008_pkg::st_mem_rd && is_mov)
      wr_data = mem_rdata;
    else if (is_alu || is_inc_dec)
      wr_data = alu_result[7:0];
    else if (is_mvi)
      wr_data = opnd[7:0];
    else
      wr_data = rd_a;
  end

  always_ff @(posedge raw_clk) begin
    if (!button_reset) begin
      state <= i8008_pkg::st_idle;
      pc    <= '0;
      flags <= '0;
    end else begin
      case (state)
        i8008_pkg::st_idle: begin
          if (run)
            state <= i8008_pkg::st_fetch_0;
        end
        i8008_pkg::st_fetch_0: state <= i8008_pkg::st_fetch_1;
        i8008_pkg::st_fetch_1: begin
          ir <= fetched;
          pc <= pc + 1'b1;
          // Operand bytes for immediates and jump targets.
          if (fetched.io_form.group == i8008_pkg::GRP_JMP && fetched.io_form.is_io)
            state <= i8008_pkg::st_out;
          else if (fetched.reg_form.group == i8008_pkg::GRP_JMP ||
                   (fetched.reg_form.group == i8008_pkg::GRP_IMM &&
                    (fetched.reg_form.src == i8008_pkg::LO_ALU_IMM ||
                     fetched.reg_form.src == i8008_pkg::LO_MVI)))
            state <= i8008_pkg::st_lo_0;
          else
            state <= i8008_pkg::st_exec;
        end
        i8008_pkg::st_lo_0: state <= i8008_pkg::st_lo_1;
        i8008_pkg::st_lo_1: begin
          opnd[7:0] <= mem_rdata;
          pc        <= pc + 1'b1;
          state     <= (grp == i8008_pkg::GRP_JMP) ? i8008_pkg::st_hi_0 : i8008_pkg::st_exec;
        end
        i8008_pkg::st_hi_0: state <= i8008_pkg::st_hi_1;
        i8008_pkg::st_hi_1: begin
          opnd[15:8] <= mem_rdata;
          pc         <= pc + 1'b1;
          state      <= i8008_pkg::st_exec;
        end
        i8008_pkg::st_exec: begin
          if ((is_jump || is_call) && taken)
            pc <= opnd;
          else if (is_ret && taken)
            pc <= top_addr;
          if (m_src)
            state <= i8008_pkg::st_mem_rd;
          else if (is_halt)
            state <= i8008_pkg::st_halted;
          else
            state <= i8008_pkg::st_fetch_0;
        end
        i8008_pkg::st_mem_rd: state <= i8008_pkg::st_fetch_0;
        i8008_pkg::st_out: begin
          if (out_grant)
            state <= i8008_pkg::st_fetch_0;
        end
        // Halted holds until reset.
        default: state <= i8008_pkg::st_halted;
      endcase

      // INR and DCR leave carry alone.
      if ((is_alu || is_inc_dec) && exec_now) begin
        flags.parity <= alu_flags.parity;
        flags.sign   <= alu_flags.sign;
        flags.zero   <= alu_flags.zero;
        if (is_alu)
          flags.carry <= alu_flags.carry;
      end
    end
  end

endmodule

// File: rtl/i8008_top.sv
/* Top level of the 8008-style core: control FSM, register file, ALU, call stack,
   program RAM and the credit-based output port. */
`timescale 1ns/1ps

module i8008_top #(
  parameter int mem_addr_w  = 8,
  parameter int stack_depth = i8008_pkg::STACK_DEPTH_DEFAULT,
  parameter int out_credits = 2
) (
  input  logic                         raw_clk,
  input  logic                         button_reset,
  input  logic                         run,
  input  logic                         load_valid,
  input  logic [mem_addr_w-1:0]        load_addr,
  input  i8008_pkg::data_t             load_data,
  output logic                         out_valid,
  output logic [i8008_pkg::PORT_W-1:0] out_port,
  output i8008_pkg::data_t             out_data,
  input  logic                         out_credit,
  output logic                         halted
);

  // Program memory bus.
  i8008_pkg::addr_t  mem_addr;
  logic              mem_we;
  i8008_pkg::data_t  mem_wdata;
  i8008_pkg::data_t  mem_rdata;

  // Register file.
  logic [2:0]        rd_sel_a;
  logic [2:0]        rd_sel_b;
  i8008_pkg::data_t  rd_a;
  i8008_pkg::data_t  rd_b;
  logic              wr_en;
  logic [2:0]        wr_sel;
  i8008_pkg::data_t  wr_data;
  i8008_pkg::addr_t  hl;

  // ALU.
  i8008_pkg::data_t  alu_a;
  i8008_pkg::data_t  alu_b;
  i8008_pkg::alu_op_e alu_op;
  logic              alu_carry_in;
  logic [8:0]        alu_result;
  i8008_pkg::flags_t alu_flags;

  // Call stack and output request.
  logic              push;
  logic              pop;
  i8008_pkg::addr_t  push_addr;
  i8008_pkg::addr_t  top_addr;
  logic              out_req;
  logic [i8008_pkg::PORT_W-1:0] port;
  i8008_pkg::data_t  data;
  logic              out_grant;

  cpu_control u_cpu_control (.*);

  reg_file u_reg_file (.*);

  alu u_alu (
    .a        (alu_a),
    .b        (alu_b),
    .op       (alu_op),
    .carry_in (alu_carry_in),
    .result   (alu_result),
    .flags    (alu_flags)
  );

  call_stack #(.stack_depth(stack_depth)) u_call_stack (.*);

  program_ram #(.mem_addr_w(mem_addr_w)) u_program_ram (.*);

  out_port #(.out_credits(out_credits)) u_out_port (.*);

endmodule

// File: tb/i8008_sva.sv
/* Bound checks on the credit handshake of the output port and on the halt state. */
`timescale 1ns/1ps

module i8008_sva #(
  parameter int max_credits   = 2,
  parameter bit watch_credits = 1'b1
) (
  input logic raw_clk,
  input logic button_reset,
  input logic out_valid,
  input logic out_credit,
  input logic halted
);

  // Outputs issued and not yet paid back.
  int in_flight;

  always_ff @(posedge raw_clk) begin
    if (!button_reset)
      in_flight <= 0;
    else
      in_flight <= in_flight + int'(out_valid) - int'(out_credit);
  end

  a_credit_limit: assert property (@(posedge raw_clk)
    disable iff (!button_reset || !watch_credits) in_flight <= max_credits)
    else $error("more outputs in flight than credits");

  a_valid_pulse: assert property (@(posedge raw_clk)
    disable iff (!button_reset || !watch_credits) out_valid |=> !out_valid)
    else $error("out_valid held longer than one cycle");

  a_halt_holds: assert property (@(posedge raw_clk)
    disable iff (!button_reset) halted |=> halted)
    else $error("halted dropped without a reset");

endmodule

// File: tb/tb_i8008.sv
/* Testbench for the 8008-style core: clock, program builder, ALU reference model,
   output comparer, credit return and the directed and random tests. */
`timescale 1ns/1ps

module tb_i8008;

  localparam int OUT_CREDITS        = 2;
  localparam int NUM_PROGRAMS       = 19;
  localparam int CYCLES_PER_PROGRAM = 400;
  localparam int PW                 = i8008_pkg::PORT_W;

  logic                   raw_clk;
  logic                   button_reset;
  logic                   run;
  logic                   load_valid;
  logic [7:0]             load_addr;
  i8008_pkg::data_t       load_data;
  logic                   out_valid;
  logic [PW-1:0]          out_port;
  i8008_pkg::data_t       out_data;
  logic                   out_credit;
  logic                   halted;

  i8008_pkg::data_t       prog [256];
  int                     prog_len;
  i8008_pkg::data_t       exp_data [$];
  logic [PW-1:0]          exp_port [$];
  int                     owed;
  logic                   hold_credits;
  logic [31:0]            lfsr_state = 32'h4a13;

  i8008_top #(
    .mem_addr_w  (8),
    .stack_depth (8),
    .out_credits (OUT_CREDITS)
  ) u_i8008_top (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .run          (run),
    .load_valid   (load_valid),
    .load_addr    (load_addr),
    .load_data    (load_data),
    .out_valid    (out_valid),
    .out_port     (out_port),
    .out_data     (out_data),
    .out_credit   (out_credit),
    .halted       (halted)
  );

  bind out_port i8008_sva u_out_sva (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .out_valid    (out_valid),
    .out_credit   (out_credit),
    .halted       (1'b0)
  );

  bind cpu_control i8008_sva #(.watch_credits(1'b0)) u_ctl_sva (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .out_valid    (out_req),
    .out_credit   (1'b0),
    .halted       (halted)
  );

  initial begin
    raw_clk = 1'b0;
    forever #4 raw_clk = ~raw_clk;
  end

  // Fibonacci LFSR with taps 32, 22, 2 and 1. One step per bit.
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  // Expected ALU result and flags from the instruction set rules.
  function automatic i8008_pkg::data_t alu_ref(input logic [2:0] op,
                                               input i8008_pkg::data_t a,
                                               input i8008_pkg::data_t b,
                                               input logic cin,
                                               output i8008_pkg::flags_t f);
    int               r;
    int               ones;
    logic             c;
    i8008_pkg::data_t d;
    c = 1'b0;
    case (op)
      3'd0: r = int'(a) + int'(b);
      3'd1: r = int'(a) + int'(b) + int'(cin);
      3'd2: r = int'(a) - int'(b);
      3'd3: r = int'(a) - int'(b) - int'(cin);
      3'd4: r = int'(a & b);
      3'd5: r = int'(a ^ b);
      3'd6: r = int'(a | b);
      default: r = int'(a) - int'(b);
    endcase
    if (op < 3'd4 || op == 3'd7)
      c = r > 255 || r < 0;
    d = r[7:0];
    ones = 0;
    for (int i = 0; i < 8; i++)
      ones += int'(d[i]);
    f.zero   = d == 8'd0;
    f.sign   = d[7];
    f.carry  = c;
    f.parity = (ones % 2) == 0;
    return d;
  endfunction

  // Bit 2 picks the true sense; bits 1:0 pick carry, zero, sign or parity.
  function automatic logic cond_ref(input logic [2:0] cc, input i8008_pkg::flags_t f);
    logic [3:0] sel;
    sel = {f.parity, f.sign, f.zero, f.carry};
    return cc[2] ? sel[cc[1:0]] : !sel[cc[1:0]];
  endfunction

  function automatic i8008_pkg::data_t enc(logic [1:0] g, logic [2:0] d, logic [2:0] s);
    return {g, d, s};
  endfunction

  function automatic i8008_pkg::data_t enc_out(logic [PW-1:0] p);
    return {2'b01, p, 1'b1};
  endfunction

  task automatic stop_with_error(string msg);
    $display("[ERROR] %0t ns: %s", $time, msg);
    $display(">>> FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_data(i8008_pkg::data_t got, i8008_pkg::data_t exp, string what);
    if (got !== exp)
      stop_with_error($sformatf("%s: data %02h, expected %02h", what, got, exp));
  endtask

  task automatic check_port(logic [PW-1:0] got, logic [PW-1:0] exp, string what);
    if (got !== exp)
      stop_with_error($sformatf("%s: port %0d, expected %0d", what, got, exp));
  endtask

  task automatic check_flag(logic got, logic exp, string what);
    if (got !== exp)
      stop_with_error($sformatf("%s: %b, expected %b", what, got, exp));
  endtask

  task automatic emit(i8008_pkg::data_t b);
    prog[prog_len] = b;
    prog_len++;
  endtask

  task automatic emit_jump(i8008_pkg::data_t op, logic [15:0] target);
    emit(op);
    emit(target[7:0]);
    emit(target[15:8]);
  endtask

  task automatic expect_out(logic [PW-1:0] p, i8008_pkg::data_t d);
    exp_port.push_back(p);
    exp_data.push_back(d);
  endtask

  // Reset, load through the load port, run to HLT and drain the credits.
  task automatic run_program(int hold_cycles);
    @(posedge raw_clk);
    button_reset <= 1'b0;
    run          <= 1'b0;
    repeat (2) @(posedge raw_clk);
    button_reset <= 1'b1;
    @(negedge raw_clk);
    check_flag(halted, 1'b0, "halted after reset");
    check_flag(out_valid, 1'b0, "out_valid after reset");
    for (int i = 0; i < prog_len; i++) begin
      @(posedge raw_clk);
      load_valid <= 1'b1;
      load_addr  <= 8'(i);
      load_data  <= prog[i];
    end
    hold_credits = hold_cycles > 0;
    @(posedge raw_clk);
    load_valid <= 1'b0;
    run        <= 1'b1;
    if (hold_cycles > 0) begin
      while (owed < OUT_CREDITS)
        @(posedge raw_clk);
      repeat (hold_cycles) @(posedge raw_clk);
      hold_credits = 1'b0;
    end
    while (halted !== 1'b1)
      @(posedge raw_clk);
    run <= 1'b0;
    repeat (10) @(negedge raw_clk);
    check_flag(halted, 1'b1, "halted stays high");
    while (owed != 0)
      @(posedge raw_clk);
    if (exp_data.size() != 0)
      stop_with_error($sformatf("%0d expected outputs never arrived", exp_data.size()));
    prog_len = 0;
  endtask

  // Checks each output against the expected queues.
  always @(negedge raw_clk) begin
    if (button_reset && out_valid === 1'b1) begin
      if (halted)
        stop_with_error("out_valid while halted");
      if (exp_data.size() == 0)
        stop_with_error("output with nothing expected");
      check_port(out_port, exp_port.pop_front(), "OUT port");
      check_data(out_data, exp_data.pop_front(), "OUT data");
      owed = owed + 1;
      if (owed > OUT_CREDITS)
        stop_with_error("more outputs in flight than credits");
    end
  end

  // Credit return after a random gap.
  initial begin
    int gap;
    out_credit = 1'b0;
    forever begin
      @(posedge raw_clk);
      if (owed > 0 && !hold_credits) begin
        gap = int'(rand_bits(3));
        repeat (gap) @(posedge raw_clk);
        out_credit <= 1'b1;
        @(posedge raw_clk);
        out_credit <= 1'b0;
        owed = owed - 1;
      end
    end
  end

  initial begin
    repeat (CYCLES_PER_PROGRAM * NUM_PROGRAMS) @(posedge raw_clk);
    $display("Timeout: the core did not finish all programs in %0d cycles",
             CYCLES_PER_PROGRAM * NUM_PROGRAMS);
    $display(">>> FAIL");
    $fatal(1, "watchdog expired");
  end

  initial begin
    i8008_pkg::flags_t f;
    i8008_pkg::data_t  a;
    i8008_pkg::data_t  b;
    i8008_pkg::data_t  r;
    i8008_pkg::data_t  y;
    logic [2:0]        op;
    button_reset = 1'b0;
    run          = 1'b0;
    load_valid   = 1'b0;
    load_addr    = '0;
    load_data    = '0;
    hold_credits = 1'b0;
    owed         = 0;
    prog_len     = 0;

    // ALU operations in register and then immediate form.
    for (int k = 0; k < 8; k++) begin
      op = 3'(k);
      f = '0;
      a = 8'(rand_bits(8));
      b = 8'(rand_bits(8));
      emit(enc(2'b00, 3'd0, 3'b110));
      emit(a);
      emit(enc(2'b00, 3'd1, 3'b110));
      emit(b);
      emit(enc(2'b10, op, 3'd1));
      emit(enc_out(5'd1));
      r = alu_ref(op, a, b, f.carry, f);
      expect_out(5'd1, (op == 3'd7) ? a : r);
      a = 8'(rand_bits(8));
      b = 8'(rand_bits(8));
      emit(enc(2'b00, 3'd0, 3'b110));
      emit(a);
      emit(enc(2'b00, op, 3'b100));
      emit(b);
      emit(enc_out(5'd2));
      emit(8'hff);
      r = alu_ref(op, a, b, f.carry, f);
      expect_out(5'd2, (op == 3'd7) ? a : r);
      run_program(0);
    end

    // Conditional jumps on flags from a random operation.
    for (int cc = 0; cc < 8; cc++) begin
      a  = 8'(rand_bits(8));
      b  = 8'(rand_bits(8));
      op = 3'(rand_bits(3));
      emit(enc(2'b00, 3'd0, 3'b110));
      emit(a);
      emit(enc(2'b00, op, 3'b100));
      emit(b);
      emit_jump(enc(2'b01, 3'(cc), 3'b000), 16'd11);
      emit(enc(2'b00, 3'd0, 3'b110));
      emit(8'd0);
      emit(enc_out(5'd3));
      emit(8'hff);
      emit(enc(2'b00, 3'd0, 3'b110));
      emit(8'd1);
      emit(enc_out(5'd3));
      emit(8'hff);
      r = alu_ref(op, a, b, 1'b0, f);
      expect_out(5'd3, cond_ref(3'(cc), f) ? 8'd1 : 8'd0);
      run_program(0);
    end

    // Memory at H:L.
    a = 8'(rand_bits(8));
    y = 8'(rand_bits(8));
    b = 8'(rand_bits(8));
    emit(enc(2'b00, 3'd5, 3'b110));
    emit(8'h00);
    emit(enc(2'b00, 3'd6, 3'b110));
    emit(8'hc0);
    emit(enc(2'b00, 3'd1, 3'b110));
    emit(a);
    emit(enc(2'b11, 3'd7, 3'd1));
    emit(enc(2'b11, 3'd2, 3'd7));
    emit(enc(2'b11, 3'd0, 3'd2));
    emit(enc_out(5'd4));
    emit(enc(2'b00, 3'd7, 3'b110));
    emit(y);
    emit(enc(2'b11, 3'd3, 3'd7));
    emit(enc(2'b00, 3'd3, 3'b000));
    emit(enc(2'b11, 3'd0, 3'd3));
    emit(enc_out(5'd5));
    emit(enc(2'b00, 3'd3, 3'b001));
    emit(enc(2'b00, 3'd3, 3'b001));
    emit(enc(2'b11, 3'd0, 3'd3));
    emit(enc_out(5'd6));
    emit(enc(2'b00, 3'd0, 3'b110));
    emit(b);
    emit(enc(2'b10, 3'd0, 3'd7));
    emit(enc_out(5'd7));
    emit(8'hff);
    expect_out(5'd4, a);
    expect_out(5'd5, y + 8'd1);
    expect_out(5'd6, y - 8'd1);
    expect_out(5'd7, b + y);
    run_program(0);

    // Calls nested eight deep. Subroutine k sits at 7 + 6*(k-1).
    a = 8'(rand_bits(8));
    emit(enc(2'b00, 3'd0, 3'b110));
    emit(a);
    emit_jump(8'h46, 16'd7);
    emit(enc_out(5'd31));
    emit(8'hff);
    for (int k = 1; k < 8; k++) begin
      emit(enc_out(5'(k)));
      emit_jump(8'h46, 16'(7 + 6 * k));
      emit(enc_out(5'(k + 16)));
      emit(8'h07);
    end
    emit(enc_out(5'd8));
    // Carry is clear, so CC, RC fall through and RNC returns.
    emit_jump(enc(2'b01, 3'd4, 3'b010), 16'd6);
    emit(enc(2'b00, 3'd4, 3'b011));
    emit(enc_out(5'd24));
    emit(enc(2'b00, 3'd0, 3'b011));
    for (int k = 1; k <= 8; k++)
      expect_out(5'(k), a);
    for (int k = 8; k >= 1; k--)
      expect_out(5'(k + 16), a);
    expect_out(5'd31, a);
    run_program(0);

    // Burst of OUTs with credits held back.
    a = 8'(rand_bits(8));
    emit(enc(2'b00, 3'd0, 3'b110));
    emit(a);
    for (int k = 0; k < 10; k++) begin
      emit(enc_out(5'd10));
      emit(enc(2'b00, 3'd0, 3'b100));
      emit(8'd1);
      expect_out(5'd10, a + 8'(k));
    end
    emit(8'hff);
    run_program(30);

    $display(">>> PASS");
    $finish;
  end

endmodule

// File: all.f
rtl/i8008_pkg.sv
rtl/alu.sv
rtl/reg_file.sv
rtl/call_stack.sv
rtl/program_ram.sv
rtl/out_port.sv
rtl/cpu_control.sv
rtl/i8008_top.sv
tb/i8008_sva.sv
tb/tb_i8008.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_i8008
FLIST     ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q '^>>> PASS$$'

clean:
	rm -rf $(OBJ_DIR)
